// ==== compile.f ====
+incdir+src
src/qu_pkg.sv
src/op_fifo.sv
src/schedule.sv
src/execute.sv
src/retire.sv
src/back_end.sv
verification/back_end_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the back end testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f compile.f --top-module back_end_tb -o back_end_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/back_end_sim > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "tests failed" "$log"; then
    exit 1
fi
exit 0

// ==== verification/back_end_tb.sv ====
`timescale 1ns/100ps
`include "qu_defs.svh"

module back_end_tb import qu_pkg::*; ();

    localparam int NUM_OPS    = 400;
    localparam int CLK_PERIOD = 10;
    localparam int RS_SIZE    = 1 << `QU_RS_ADDR_W;

    logic      clk;
    logic      reset;
    logic      schedule_en;
    rs_addr_t  rs_rd_addr0;
    rs_addr_t  rs_rd_addr1;
    rs_addr_t  rs_rd_addr2;
    rs_addr_t  rs_rd_addr3;
    rs_cell_t  rs_rd_cell0;
    rs_cell_t  rs_rd_cell1;
    rs_cell_t  rs_rd_cell2;
    rs_cell_t  rs_rd_cell3;
    logic      rs_issue_en;
    rs_addr_t  rs_issue_addr;
    logic      prf_wr_en;
    prf_addr_t prf_wr_addr;
    data_t     prf_wr_data;
    logic      busy_clr_en;
    prf_addr_t busy_clr_addr;
    logic      redirect;
    data_t     redirect_pc;

    rs_cell_t  rs_mem [RS_SIZE];
    rs_cell_t  exp_q [$];
    int        errors;
    int        issued;
    int        written;
    int        redirects;
    logic      issue_seen;
    rs_addr_t  issue_slot;
    tag_t      next_tag;

    back_end DUT (.*);

    // station reads are combinational
    assign rs_rd_cell0 = rs_mem[rs_rd_addr0];
    assign rs_rd_cell1 = rs_mem[rs_rd_addr1];
    assign rs_rd_cell2 = rs_mem[rs_rd_addr2];
    assign rs_rd_cell3 = rs_mem[rs_rd_addr3];

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_error(input string msg);
        $display("ERR @%0t: %s", $time, msg);
        errors++;
    endtask

    function automatic rs_cell_t random_cell(input tag_t tag);
        rs_cell_t c;
        data_t    a;
        c = '0;
        a = $urandom;
        c[`QU_IW_VALID]                  = 1'b1;
        c[`QU_IW_READY]                  = ($urandom % 4) != 0;
        c[`QU_IW_TAG +: `QU_TAG_W]       = tag;
        c[`QU_IW_OPC +: `QU_OPC_W]       = opcode_t'($urandom % 8);
        c[`QU_IW_DST +: `QU_PRF_ADDR_W]  = prf_addr_t'($urandom % 64);
        c[`QU_IW_A +: `QU_DATA_W]        = a;
        // equal operands half the time so both branch outcomes show up
        c[`QU_IW_B +: `QU_DATA_W]        = (($urandom % 2) == 0) ? a : data_t'($urandom);
        c[`QU_IW_TGT +: `QU_DATA_W]      = $urandom;
        return c;
    endfunction

    function automatic logic is_branch(input rs_cell_t c);
        opcode_t opc;
        opc = c[`QU_IW_OPC +: `QU_OPC_W];
        return (opc == OPC_BEQ) || (opc == OPC_BNE);
    endfunction

    function automatic logic branch_taken(input rs_cell_t c);
        opcode_t opc;
        logic    same;
        opc  = c[`QU_IW_OPC +: `QU_OPC_W];
        same = c[`QU_IW_A +: `QU_DATA_W] == c[`QU_IW_B +: `QU_DATA_W];
        if (opc == OPC_BEQ) begin
            return same;
        end else if (opc == OPC_BNE) begin
            return !same;
        end
        return 1'b0;
    endfunction

    function automatic data_t expected_value(input rs_cell_t c);
        opcode_t opc;
        data_t   a;
        data_t   b;
        opc = c[`QU_IW_OPC +: `QU_OPC_W];
        a   = c[`QU_IW_A +: `QU_DATA_W];
        b   = c[`QU_IW_B +: `QU_DATA_W];
        if (opc == OPC_ADD) return a + b;
        if (opc == OPC_SUB) return a - b;
        if (opc == OPC_AND) return a & b;
        if (opc == OPC_OR) return a | b;
        if (opc == OPC_XOR) return a ^ b;
        if (opc == OPC_SLT) return ($signed(a) < $signed(b)) ? data_t'(1) : data_t'(0);
        return '0;
    endfunction

    // untaken branches retire without any visible output
    task automatic drop_silent_branches();
        while (exp_q.size() > 0 && is_branch(exp_q[0]) && !branch_taken(exp_q[0])) begin
            void'(exp_q.pop_front());
        end
    endtask

    task automatic update_station();
        if (issue_seen) begin
            rs_mem[issue_slot][`QU_IW_VALID] = 1'b0;
            issue_seen = 1'b0;
        end
        for (int i = 0; i < RS_SIZE; i++) begin
            if (!rs_mem[i][`QU_IW_VALID]) begin
                if (($urandom % 4) == 0) begin
                    rs_mem[i] = random_cell(next_tag);
                    next_tag++;
                end
            end else if (!rs_mem[i][`QU_IW_READY] && (($urandom % 2) == 0)) begin
                rs_mem[i][`QU_IW_READY] = 1'b1;
            end
        end
    endtask

    // quiet outputs through reset and the cycle after
    assert property (@(posedge clk)
        reset |=> !rs_issue_en && !prf_wr_en && !busy_clr_en && !redirect)
        else report_error("output active during reset or the cycle after it");

    assert property (@(posedge clk) disable iff (reset) busy_clr_en == prf_wr_en)
        else report_error("busy clear and register write out of step");

    assert property (@(posedge clk) disable iff (reset)
        prf_wr_en |-> busy_clr_addr == prf_wr_addr)
        else report_error("busy clear address differs from write address");

    assert property (@(posedge clk) disable iff (reset) rs_issue_en |-> schedule_en)
        else report_error("issue while schedule_en is low");

    // read ports cover four consecutive entries
    assert property (@(posedge clk) disable iff (reset)
        rs_rd_addr1 == rs_rd_addr0 + rs_addr_t'(1) &&
        rs_rd_addr2 == rs_rd_addr0 + rs_addr_t'(2) &&
        rs_rd_addr3 == rs_rd_addr0 + rs_addr_t'(3))
        else report_error("station read addresses not consecutive");

    // mid-cycle sampling, all values settled
    always @(negedge clk) begin
        rs_cell_t head;
        if (!reset) begin
            if (prf_wr_en || redirect) begin
                drop_silent_branches();
            end
            if (prf_wr_en) begin
                written++;
                if (exp_q.size() == 0) begin
                    report_error("register write with no op outstanding");
                end else begin
                    head = exp_q.pop_front();
                    assert (!is_branch(head))
                        else report_error("register write where a taken branch was due");
                    assert (prf_wr_addr == head[`QU_IW_DST +: `QU_PRF_ADDR_W])
                        else report_error($sformatf("write addr %0d, expected %0d",
                            prf_wr_addr, head[`QU_IW_DST +: `QU_PRF_ADDR_W]));
                    assert (prf_wr_data == expected_value(head))
                        else report_error($sformatf("write data %h, expected %h",
                            prf_wr_data, expected_value(head)));
                end
            end
            if (redirect) begin
                redirects++;
                if (exp_q.size() == 0) begin
                    report_error("redirect with no branch outstanding");
                end else begin
                    head = exp_q.pop_front();
                    assert (is_branch(head) && branch_taken(head))
                        else report_error("redirect where no taken branch was due");
                    assert (redirect_pc == head[`QU_IW_TGT +: `QU_DATA_W])
                        else report_error($sformatf("redirect pc %h, expected %h",
                            redirect_pc, head[`QU_IW_TGT +: `QU_DATA_W]));
                end
                // younger ops are dropped by the flush
                exp_q.delete();
            end
            if (rs_issue_en) begin
                assert (rs_mem[rs_issue_addr][`QU_IW_VALID] && rs_mem[rs_issue_addr][`QU_IW_READY])
                    else report_error($sformatf("issue of entry %0d, not valid and ready",
                        rs_issue_addr));
                exp_q.push_back(rs_mem[rs_issue_addr]);
                issued++;
                issue_seen = 1'b1;
                issue_slot = rs_issue_addr;
            end
        end
    end

    initial begin
        #(NUM_OPS * 20 * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, %0d of %0d ops issued",
            NUM_OPS * 20, issued, NUM_OPS);
        $display("tests failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h327f_af4a));
        errors      = 0;
        issued      = 0;
        written     = 0;
        redirects   = 0;
        issue_seen  = 1'b0;
        issue_slot  = '0;
        next_tag    = '0;
        reset       = 1'b1;
        // ready cells and scheduling on, reset alone keeps the core quiet
        schedule_en = 1'b1;
        for (int i = 0; i < RS_SIZE; i++) begin
            rs_mem[i] = random_cell(next_tag);
            next_tag++;
        end
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;
        schedule_en = 1'b0;
        @(posedge clk);
        while (issued < NUM_OPS) begin
            @(posedge clk);
            #1;
            update_station();
            schedule_en = ($urandom % 4) != 0;
        end
        schedule_en = 1'b0;
        repeat (40) @(posedge clk);
        drop_silent_branches();
        if (exp_q.size() != 0) begin
            report_error($sformatf("%0d issued ops never retired", exp_q.size()));
        end
        $display("errors %0d, issued %0d, written %0d, redirects %0d",
            errors, issued, written, redirects);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== src/back_end.sv ====
`timescale 1ns/100ps
`include "qu_defs.svh"

module back_end import qu_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      schedule_en,
    output rs_addr_t  rs_rd_addr0,
    output rs_addr_t  rs_rd_addr1,
    output rs_addr_t  rs_rd_addr2,
    output rs_addr_t  rs_rd_addr3,
    input  rs_cell_t  rs_rd_cell0,
    input  rs_cell_t  rs_rd_cell1,
    input  rs_cell_t  rs_rd_cell2,
    input  rs_cell_t  rs_rd_cell3,
    output logic      rs_issue_en,
    output rs_addr_t  rs_issue_addr,
    output logic      prf_wr_en,
    output prf_addr_t prf_wr_addr,
    output data_t     prf_wr_data,
    output logic      busy_clr_en,
    output prf_addr_t busy_clr_addr,
    output logic      redirect,
    output data_t     redirect_pc
);

    logic       flush;
    logic       issue_push;
    rs_cell_t   issue_cell;
    logic       issue_pop;
    rs_cell_t   issue_head;
    logic       issue_empty;
    logic       done_push;
    done_word_t done_word;
    logic       done_pop;
    done_word_t done_head;
    logic       done_empty;

    // redirect is already registered in retire
    assign flush = reset || redirect;

    schedule u_schedule (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .schedule_en  (schedule_en),
        .issue_credit (issue_pop),
        .rs_rd_cell0  (rs_rd_cell0),
        .rs_rd_cell1  (rs_rd_cell1),
        .rs_rd_cell2  (rs_rd_cell2),
        .rs_rd_cell3  (rs_rd_cell3),
        .rs_rd_addr0  (rs_rd_addr0),
        .rs_rd_addr1  (rs_rd_addr1),
        .rs_rd_addr2  (rs_rd_addr2),
        .rs_rd_addr3  (rs_rd_addr3),
        .rs_issue_en  (rs_issue_en),
        .rs_issue_addr(rs_issue_addr),
        .issue_push   (issue_push),
        .issue_cell   (issue_cell)
    );

    op_fifo #(.WIDTH(`QU_IW_W), .DEPTH(`QU_FIFO_DEPTH)) issue_q (
        .clk      (clk),
        .reset    (reset),
        .flush    (flush),
        .push     (issue_push),
        .push_data(issue_cell),
        .pop      (issue_pop),
        .pop_data (issue_head),
        .empty    (issue_empty)
    );

    execute u_execute (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .head_cell    (issue_head),
        .head_empty   (issue_empty),
        .result_credit(done_pop),
        .head_pop     (issue_pop),
        .done_push    (done_push),
        .done_word    (done_word)
    );

    op_fifo #(.WIDTH(`QU_DW_W), .DEPTH(`QU_FIFO_DEPTH)) done_q (
        .clk      (clk),
        .reset    (reset),
        .flush    (flush),
        .push     (done_push),
        .push_data(done_word),
        .pop      (done_pop),
        .pop_data (done_head),
        .empty    (done_empty)
    );

    retire u_retire (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .done_word    (done_head),
        .done_empty   (done_empty),
        .done_pop     (done_pop),
        .prf_wr_en    (prf_wr_en),
        .prf_wr_addr  (prf_wr_addr),
        .prf_wr_data  (prf_wr_data),
        .busy_clr_en  (busy_clr_en),
        .busy_clr_addr(busy_clr_addr),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc)
    );

endmodule

// ==== src/retire.sv ====
`timescale 1ns/100ps
`include "qu_defs.svh"

module retire import qu_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       flush,
    input  done_word_t done_word,
    input  logic       done_empty,
    output logic       done_pop,
    output logic       prf_wr_en,
    output prf_addr_t  prf_wr_addr,
    output data_t      prf_wr_data,
    output logic       busy_clr_en,
    output prf_addr_t  busy_clr_addr,
    output logic       redirect,
    output data_t      redirect_pc
);

    opcode_t   opc;
    prf_addr_t dst;
    logic      is_branch;

    assign opc       = done_word[`QU_DW_OPC +: `QU_OPC_W];
    assign dst       = done_word[`QU_DW_DST +: `QU_PRF_ADDR_W];
    assign is_branch = (opc == OPC_BEQ) || (opc == OPC_BNE);

    // never stalls
    assign done_pop = !done_empty && !flush;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            prf_wr_en   <= 1'b0;
            busy_clr_en <= 1'b0;
            redirect    <= 1'b0;
        end else begin
            prf_wr_en   <= done_pop && !is_branch;
            busy_clr_en <= done_pop && !is_branch;
            redirect    <= done_pop && done_word[`QU_DW_TAKEN];
        end
    end

    always_ff @(posedge clk) begin
        if (done_pop) begin
            prf_wr_addr   <= dst;
            prf_wr_data   <= done_word[`QU_DW_VALUE +: `QU_DATA_W];
            busy_clr_addr <= dst;
            redirect_pc   <= done_word[`QU_DW_TGT +: `QU_DATA_W];
        end
    end

    // taken flag from execute only ever belongs to a branch
    assert property (@(posedge clk) disable iff (reset) redirect |-> $past(is_branch))
        else $error("redirect for a non-branch op");

endmodule

// ==== src/execute.sv ====
`timescale 1ns/100ps
`include "qu_defs.svh"

module execute import qu_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       flush,
    input  rs_cell_t   head_cell,
    input  logic       head_empty,
    input  logic       result_credit,
    output logic       head_pop,
    output logic       done_push,
    output done_word_t done_word
);

    localparam int CREDIT_W = $clog2(`QU_FIFO_DEPTH + 1);

    opcode_t             opc;
    data_t               op_a;
    data_t               op_b;
    data_t               value;
    logic                taken;
    done_word_t          next_word;
    logic [CREDIT_W-1:0] credit;

    assign opc  = head_cell[`QU_IW_OPC +: `QU_OPC_W];
    assign op_a = head_cell[`QU_IW_A +: `QU_DATA_W];
    assign op_b = head_cell[`QU_IW_B +: `QU_DATA_W];

    // one slot of result queue reserved per pop
    assign head_pop = !head_empty && (credit != '0) && !flush;

    always_comb begin
        value = '0;
        taken = 1'b0;
        case (opc)
            OPC_ADD: value = op_a + op_b;
            OPC_SUB: value = op_a - op_b;
            OPC_AND: value = op_a & op_b;
            OPC_OR:  value = op_a | op_b;
            OPC_XOR: value = op_a ^ op_b;
            OPC_SLT: value = ($signed(op_a) < $signed(op_b)) ? data_t'(1) : '0;
            OPC_BEQ: taken = (op_a == op_b);
            OPC_BNE: taken = (op_a != op_b);
        endcase
    end

    always_comb begin
        next_word = '0;
        next_word[`QU_DW_TAG +: `QU_TAG_W]        = head_cell[`QU_IW_TAG +: `QU_TAG_W];
        next_word[`QU_DW_OPC +: `QU_OPC_W]        = opc;
        next_word[`QU_DW_DST +: `QU_PRF_ADDR_W]   = head_cell[`QU_IW_DST +: `QU_PRF_ADDR_W];
        next_word[`QU_DW_VALUE +: `QU_DATA_W]     = value;
        next_word[`QU_DW_TAKEN]                   = taken;
        next_word[`QU_DW_TGT +: `QU_DATA_W]       = head_cell[`QU_IW_TGT +: `QU_DATA_W];
    end

    always_ff @(posedge clk) begin
        if (head_pop) begin
            done_word <= next_word;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            done_push <= 1'b0;
            credit    <= CREDIT_W'(`QU_FIFO_DEPTH);
        end else begin
            done_push <= head_pop;
            if (head_pop && !result_credit) begin
                credit <= credit - 1'b1;
            end else if (result_credit && !head_pop) begin
                credit <= credit + 1'b1;
            end
        end
    end

endmodule

// ==== src/schedule.sv ====
`timescale 1ns/100ps
`include "qu_defs.svh"

module schedule import qu_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     flush,
    input  logic     schedule_en,
    input  logic     issue_credit,
    input  rs_cell_t rs_rd_cell0,
    input  rs_cell_t rs_rd_cell1,
    input  rs_cell_t rs_rd_cell2,
    input  rs_cell_t rs_rd_cell3,
    output rs_addr_t rs_rd_addr0,
    output rs_addr_t rs_rd_addr1,
    output rs_addr_t rs_rd_addr2,
    output rs_addr_t rs_rd_addr3,
    output logic     rs_issue_en,
    output rs_addr_t rs_issue_addr,
    output logic     issue_push,
    output rs_cell_t issue_cell
);

    localparam int CREDIT_W = $clog2(`QU_FIFO_DEPTH + 1);
    localparam int SEL_W    = $clog2(`QU_WINDOW);

    rs_addr_t            base;
    logic [CREDIT_W-1:0] credit;
    rs_cell_t            cells [`QU_WINDOW];
    logic                any_ready;
    logic [SEL_W-1:0]    sel;

    // window of consecutive entries, wraps around the station
    assign rs_rd_addr0 = base;
    assign rs_rd_addr1 = base + rs_addr_t'(1);
    assign rs_rd_addr2 = base + rs_addr_t'(2);
    assign rs_rd_addr3 = base + rs_addr_t'(3);

    assign cells[0] = rs_rd_cell0;
    assign cells[1] = rs_rd_cell1;
    assign cells[2] = rs_rd_cell2;
    assign cells[3] = rs_rd_cell3;

    // lowest numbered port wins
    always_comb begin
        any_ready = 1'b0;
        sel       = '0;
        for (int i = `QU_WINDOW - 1; i >= 0; i--) begin
            if (cells[i][`QU_IW_VALID] && cells[i][`QU_IW_READY]) begin
                any_ready = 1'b1;
                sel       = SEL_W'(i);
            end
        end
    end

    assign rs_issue_en   = schedule_en && !flush && (credit != '0) && any_ready;
    assign rs_issue_addr = base + rs_addr_t'(sel);
    assign issue_push    = rs_issue_en;
    assign issue_cell    = cells[sel];

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            base   <= '0;
            credit <= CREDIT_W'(`QU_FIFO_DEPTH);
        end else begin
            // hold the base after an issue, more ready cells may sit here
            if (schedule_en && !rs_issue_en) begin
                base <= base + rs_addr_t'(`QU_WINDOW);
            end
            if (issue_push && !issue_credit) begin
                credit <= credit - 1'b1;
            end else if (issue_credit && !issue_push) begin
                credit <= credit + 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset) credit <= CREDIT_W'(`QU_FIFO_DEPTH))
        else $error("issue credit above queue depth");

endmodule

// ==== src/op_fifo.sv ====
`timescale 1ns/100ps

module op_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             flush,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    input  logic             pop,
    output logic [WIDTH-1:0] pop_data,
    output logic             empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign empty    = (count == '0);
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // the sender's credit counter must keep pushes off a full queue
    assert property (@(posedge clk) disable iff (reset) push |-> count < CNT_W'(DEPTH))
        else $error("op_fifo push while full");

    assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
        else $error("op_fifo pop while empty");

endmodule

// ==== src/qu_pkg.sv ====
`include "qu_defs.svh"

package qu_pkg;

    typedef logic [`QU_DATA_W-1:0]     data_t;
    typedef logic [`QU_PRF_ADDR_W-1:0] prf_addr_t;
    typedef logic [`QU_TAG_W-1:0]      tag_t;
    typedef logic [`QU_RS_ADDR_W-1:0]  rs_addr_t;
    typedef logic [`QU_OPC_W-1:0]      opcode_t;

    // valid, ready, tag, opcode, dst, a, b, target from bit 0 upward
    typedef logic [`QU_IW_W-1:0]       rs_cell_t;

    // tag, opcode, dst, value, taken, target from bit 0 upward
    typedef logic [`QU_DW_W-1:0]       done_word_t;

    // alu ops
    localparam opcode_t OPC_ADD = opcode_t'(0);
    localparam opcode_t OPC_SUB = opcode_t'(1);
    localparam opcode_t OPC_AND = opcode_t'(2);
    localparam opcode_t OPC_OR  = opcode_t'(3);
    localparam opcode_t OPC_XOR = opcode_t'(4);
    // signed compare, result is 1 or 0
    localparam opcode_t OPC_SLT = opcode_t'(5);

    // branches, predicted not taken
    localparam opcode_t OPC_BEQ = opcode_t'(6);
    localparam opcode_t OPC_BNE = opcode_t'(7);

endpackage

// ==== src/qu_defs.svh ====
`ifndef QU_DEFS_SVH
`define QU_DEFS_SVH

`define QU_DATA_W       32
`define QU_PRF_ADDR_W   6
`define QU_TAG_W        4
`define QU_RS_ADDR_W    4
`define QU_WINDOW       4
`define QU_FIFO_DEPTH   4
`define QU_OPC_W        3

// issue word, lsb of each field
`define QU_IW_VALID     0
`define QU_IW_READY     1
`define QU_IW_TAG       2
`define QU_IW_OPC       6
`define QU_IW_DST       9
`define QU_IW_A         15
`define QU_IW_B         47
`define QU_IW_TGT       79
`define QU_IW_W         111

// done word
`define QU_DW_TAG       0
`define QU_DW_OPC       4
`define QU_DW_DST       7
`define QU_DW_VALUE     13
`define QU_DW_TAKEN     45
`define QU_DW_TGT       46
`define QU_DW_W         78

`endif
